//--- compile.f
logic/id_pkg.sv
logic/imm_gen.sv
logic/insn_decode.sv
logic/id_ex_reg.sv
logic/id_stage.sv
sim/id_checker.sv
sim/tb_id_stage.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module tb_id_stage \
		-f compile.f -Mdir obj_dir -o tb_id_stage
	./obj_dir/tb_id_stage | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_id_stage.sv
// Testbench for the decode stage.
// Drives LFSR-built instructions and random register read data on the
// IF/ID side of the DUT; id_checker does all comparing. A watchdog ends
// the run if the stimulus or the closing report stalls.

`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
    import id_pkg::*;
();

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 4;
    localparam int    N_TESTS      = 2000;
    localparam int    DRAIN_CYCLES = 4;
    localparam int    WATCHDOG_NS  = (N_TESTS + RESET_CYCLES + DRAIN_CYCLES + 50) * CLK_PERIOD;
    localparam word_t LFSR_TAPS    = 32'h8020_0003;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      if_en_i;
    word_t     if_insn_i;
    word_t     gpr_rd_data_0_i;
    word_t     gpr_rd_data_1_i;
    reg_addr_t gpr_rd_addr_0_o;
    reg_addr_t gpr_rd_addr_1_o;
    logic      id_en_o;
    alu_op_t   id_alu_op_o;
    word_t     id_alu_in_0_o;
    word_t     id_alu_in_1_o;
    mem_op_t   id_mem_op_o;
    word_t     id_mem_wr_data_o;
    gpr_src_t  id_gpr_src_o;
    reg_addr_t id_dst_addr_o;
    logic      id_gpr_we_o;
    logic      id_illegal_o;

    logic  report_req;
    logic  report_done;
    word_t errors;
    word_t lfsr_state = 32'h5ed9;

    id_stage i_dut (.*);

    id_checker i_checker (
        .clk(clk), .reset_i(reset_i), .if_en_i(if_en_i), .if_insn_i(if_insn_i),
        .gpr_rd_data_0_i(gpr_rd_data_0_i), .gpr_rd_data_1_i(gpr_rd_data_1_i),
        .gpr_rd_addr_0_i(gpr_rd_addr_0_o), .gpr_rd_addr_1_i(gpr_rd_addr_1_o),
        .id_en_i(id_en_o), .id_alu_op_i(id_alu_op_o),
        .id_alu_in_0_i(id_alu_in_0_o), .id_alu_in_1_i(id_alu_in_1_o),
        .id_mem_op_i(id_mem_op_o), .id_mem_wr_data_i(id_mem_wr_data_o),
        .id_gpr_src_i(id_gpr_src_o), .id_dst_addr_i(id_dst_addr_o),
        .id_gpr_we_i(id_gpr_we_o), .id_illegal_i(id_illegal_o),
        .report_req_i(report_req), .report_done_o(report_done), .errors_o(errors)
    );

    // clock starts low from its declaration
    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic word_t take_bits(input int n);
        word_t val;
        logic  b;
        int    k;
        val = '0;
        for (k = 0; k < n; k++) begin
            b          = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? LFSR_TAPS : 32'h0);
            val        = {val[30:0], b};
        end
        return val;
    endfunction

    // ------------------------------------------------------------------------
    // instruction builder
    // ------------------------------------------------------------------------
    // ctl[7:4] picks the kind and ctl[10:8] the funct3
    // ctl[13:11] all zero gives a wrong funct
    function automatic word_t build_insn(input word_t ctl, input word_t raw);
        logic    wrong;
        opcode_t op;
        funct3_t f3;
        funct7_t f7;
        wrong = (ctl[13:11] == 3'b000);
        f3    = raw[14:12];
        f7    = raw[31:25];
        case (ctl[7:4])
            4'd1: return {raw[31:7], OP_NOP};
            4'd2, 4'd3, 4'd4: begin
                op = OP_LOAD;
                // fold the pick onto LB..LHU
                case (ctl[10:8])
                    3'd3:    f3 = F3_LBU;
                    3'd6:    f3 = F3_LHU;
                    3'd7:    f3 = F3_LW;
                    default: f3 = ctl[10:8];
                endcase
                if (wrong) f3 = raw[14:12];
            end
            4'd5, 4'd6, 4'd7: begin
                op = OP_STORE;
                f3 = (ctl[9:8] == 2'b11) ? F3_SW : {1'b0, ctl[9:8]};
                if (wrong) f3 = raw[14:12];
            end
            4'd8, 4'd9, 4'd10: begin
                // pick includes slti and sltiu, which are illegal here
                op = OP_ALU_IMM;
                f3 = ctl[10:8];
                if (!wrong && (f3 == F3_SLL || f3 == F3_SR)) begin
                    f7 = (f3 == F3_SR && ctl[14]) ? F7_ALT : F7_BASE;
                end
            end
            4'd11, 4'd12, 4'd13, 4'd14: begin
                op = OP_ALU_REG;
                f3 = ctl[10:8];
                if (!wrong) f7 = ((f3 == F3_ADD || f3 == F3_SR) && ctl[14]) ? F7_ALT : F7_BASE;
            end
            default: return raw;
        endcase
        return {f7, raw[24:15], f3, raw[11:7], op};
    endfunction

    task automatic drive_random();
        word_t ctl;
        word_t raw;
        ctl = take_bits(16);
        raw = take_bits(32);
        // enable high 15 times in 16
        if_en_i         <= (ctl[3:0] != 4'h0);
        if_insn_i       <= build_insn(ctl, raw);
        gpr_rd_data_0_i <= take_bits(32);
        gpr_rd_data_1_i <= take_bits(32);
    endtask

    // ------------------------------------------------------------------------
    // stimulus and verdict
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int c;
        reset_i         = 1'b1;
        if_en_i         = 1'b0;
        if_insn_i       = '0;
        gpr_rd_data_0_i = '0;
        gpr_rd_data_1_i = '0;
        report_req      = 1'b0;
        // random traffic runs through reset as well
        for (c = 0; c < RESET_CYCLES + N_TESTS; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) reset_i <= 1'b0;
            drive_random();
        end
        @(posedge clk);
        if_en_i <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        report_req <= 1'b1;
        wait (report_done === 1'b1);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/id_checker.sv
// Scoreboard for the decode stage testbench.
// Samples the DUT ports on the falling clock edge, runs its own reference
// decode of the inputs seen one cycle earlier and compares every ID/EX
// output. On report_req_i it checks category coverage and prints the counts.

`timescale 1ns/1ps
`default_nettype none

module id_checker
    import id_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire logic      if_en_i,
    input  wire word_t     if_insn_i,
    input  wire word_t     gpr_rd_data_0_i,
    input  wire word_t     gpr_rd_data_1_i,
    input  wire reg_addr_t gpr_rd_addr_0_i,
    input  wire reg_addr_t gpr_rd_addr_1_i,
    input  wire logic      id_en_i,
    input  wire alu_op_t   id_alu_op_i,
    input  wire word_t     id_alu_in_0_i,
    input  wire word_t     id_alu_in_1_i,
    input  wire mem_op_t   id_mem_op_i,
    input  wire word_t     id_mem_wr_data_i,
    input  wire gpr_src_t  id_gpr_src_i,
    input  wire reg_addr_t id_dst_addr_i,
    input  wire logic      id_gpr_we_i,
    input  wire logic      id_illegal_i,
    input  wire logic      report_req_i,
    output logic           report_done_o,
    output word_t          errors_o
);

    // inputs as sampled one cycle back
    logic  have_prev = 1'b0;
    logic  p_reset;
    logic  p_en;
    word_t p_insn;
    word_t p_rd0;
    word_t p_rd1;

    int n_cycles;
    int n_mismatch;
    int n_holes;
    // per-category counts
    int n_reset;
    int n_idle;
    int n_nop;
    int n_load;
    int n_store;
    int n_imm;
    int n_reg;
    int n_illegal;

    assign errors_o = word_t'(n_mismatch + n_holes);

    task automatic compare_field(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            n_mismatch++;
            $display("mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference decode
    // ------------------------------------------------------------------------

    // NOP result marks a funct combination outside the kept set
    function automatic alu_op_t alu_from_funct(input funct3_t f3, input funct7_t f7,
                                               input logic is_reg);
        alu_op_t op;
        op = ALU_OP_NOP;
        case (f3)
            F3_ADD: begin
                if (!is_reg || f7 == F7_BASE) op = ALU_OP_ADD;
                else if (f7 == F7_ALT) op = ALU_OP_SUB;
            end
            F3_SR: begin
                if (f7 == F7_BASE) op = ALU_OP_SRL;
                else if (f7 == F7_ALT) op = ALU_OP_SRA;
            end
            F3_SLL: if (f7 == F7_BASE) op = ALU_OP_SLL;
            // immediate forms carry imm bits in funct7
            F3_XOR: if (!is_reg || f7 == F7_BASE) op = ALU_OP_XOR;
            F3_OR:  if (!is_reg || f7 == F7_BASE) op = ALU_OP_OR;
            F3_AND: if (!is_reg || f7 == F7_BASE) op = ALU_OP_AND;
            default: op = ALU_OP_NOP;
        endcase
        return op;
    endfunction

    task automatic decode_model(
        input  logic     en,
        input  word_t    insn,
        input  word_t    rd1,
        output alu_op_t  alu,
        output mem_op_t  mem,
        output logic     we,
        output logic     ill,
        output gpr_src_t src,
        output word_t    in1
    );
        funct3_t f3;
        f3  = insn[14:12];
        alu = ALU_OP_NOP;
        mem = MEM_OP_NOP;
        we  = 1'b0;
        ill = 1'b0;
        src = GPR_SRC_EX;
        in1 = rd1;
        if (en) begin
            case (insn[6:0])
                OP_NOP: ill = 1'b0;
                OP_LOAD: begin
                    in1 = {{20{insn[31]}}, insn[31:20]};
                    alu = ALU_OP_ADD;
                    we  = 1'b1;
                    src = GPR_SRC_MEM;
                    case (f3)
                        3'b000:  mem = MEM_OP_LB;
                        3'b001:  mem = MEM_OP_LH;
                        3'b010:  mem = MEM_OP_LW;
                        3'b100:  mem = MEM_OP_LBU;
                        3'b101:  mem = MEM_OP_LHU;
                        default: ill = 1'b1;
                    endcase
                end
                OP_STORE: begin
                    in1 = {{20{insn[31]}}, insn[31:25], insn[11:7]};
                    alu = ALU_OP_ADD;
                    case (f3)
                        3'b000:  mem = MEM_OP_SB;
                        3'b001:  mem = MEM_OP_SH;
                        3'b010:  mem = MEM_OP_SW;
                        default: ill = 1'b1;
                    endcase
                end
                OP_ALU_IMM: begin
                    // shifts use the zero-extended shamt
                    if (f3 == F3_SLL || f3 == F3_SR) in1 = {27'b0, insn[24:20]};
                    else in1 = {{20{insn[31]}}, insn[31:20]};
                    alu = alu_from_funct(f3, insn[31:25], 1'b0);
                    ill = (alu == ALU_OP_NOP);
                    we  = 1'b1;
                end
                OP_ALU_REG: begin
                    alu = alu_from_funct(f3, insn[31:25], 1'b1);
                    ill = (alu == ALU_OP_NOP);
                    we  = 1'b1;
                end
                default: ill = 1'b1;
            endcase
            // illegal insn has no side effects
            if (ill) begin
                alu = ALU_OP_NOP;
                mem = MEM_OP_NOP;
                we  = 1'b0;
                src = GPR_SRC_EX;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // per-cycle comparison
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : check_cycle
        alu_op_t  e_alu;
        mem_op_t  e_mem;
        logic     e_we;
        logic     e_ill;
        gpr_src_t e_src;
        word_t    e_in1;

        // read addresses follow in the same cycle
        compare_field("gpr_rd_addr_0_o", word_t'(if_insn_i[19:15]), word_t'(gpr_rd_addr_0_i));
        compare_field("gpr_rd_addr_1_o", word_t'(if_insn_i[24:20]), word_t'(gpr_rd_addr_1_i));

        if (have_prev) begin
            n_cycles++;
            // reset forces the same idle controls as a disabled cycle
            decode_model(p_en && !p_reset, p_insn, p_rd1, e_alu, e_mem, e_we, e_ill,
                         e_src, e_in1);
            compare_field("id_en_o", word_t'(p_en && !p_reset), word_t'(id_en_i));
            compare_field("id_alu_op_o", word_t'(e_alu), word_t'(id_alu_op_i));
            compare_field("id_mem_op_o", word_t'(e_mem), word_t'(id_mem_op_i));
            compare_field("id_gpr_we_o", word_t'(e_we), word_t'(id_gpr_we_i));
            compare_field("id_illegal_o", word_t'(e_ill), word_t'(id_illegal_i));

            if (p_reset) begin
                n_reset++;
            end else begin
                // data fields are not reset and are checked only outside reset
                compare_field("id_alu_in_0_o", p_rd0, id_alu_in_0_i);
                compare_field("id_mem_wr_data_o", p_rd1, id_mem_wr_data_i);
                compare_field("id_dst_addr_o", word_t'(p_insn[11:7]), word_t'(id_dst_addr_i));
                compare_field("id_gpr_src_o", word_t'(e_src), word_t'(id_gpr_src_i));
                if (p_en && !e_ill) begin
                    compare_field("id_alu_in_1_o", e_in1, id_alu_in_1_i);
                end

                if (!p_en) n_idle++;
                else if (e_ill) n_illegal++;
                else begin
                    case (p_insn[6:0])
                        OP_NOP:     n_nop++;
                        OP_LOAD:    n_load++;
                        OP_STORE:   n_store++;
                        OP_ALU_IMM: n_imm++;
                        default:    n_reg++;
                    endcase
                end
            end
        end

        p_reset   = reset_i;
        p_en      = if_en_i;
        p_insn    = if_insn_i;
        p_rd0     = gpr_rd_data_0_i;
        p_rd1     = gpr_rd_data_1_i;
        have_prev = 1'b1;
    end

    // ------------------------------------------------------------------------
    // closing report
    // ------------------------------------------------------------------------
    task automatic require_seen(input string what, input int count);
        if (count == 0) begin
            n_holes++;
            $display("coverage hole: no %s were checked", what);
        end
    endtask

    always @(posedge report_req_i) begin
        require_seen("reset cycles", n_reset);
        require_seen("disabled cycles", n_idle);
        require_seen("nop instructions", n_nop);
        require_seen("loads", n_load);
        require_seen("stores", n_store);
        require_seen("immediate alu ops", n_imm);
        require_seen("register alu ops", n_reg);
        require_seen("illegal encodings", n_illegal);
        $display("checked %0d cycles, %0d mismatches, %0d coverage holes",
                 n_cycles, n_mismatch, n_holes);
        // error total settles before the testbench sees done
        report_done_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/id_stage.sv
// Instruction-decode stage of the RV32I integer pipeline.
// Takes the IF/ID instruction and enable, drives the two register-file
// read addresses combinationally, and delivers the decoded controls and
// operands from the ID/EX register one cycle later.

`timescale 1ns/1ps
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    // from IF/ID
    input  wire logic  if_en_i,
    input  wire word_t if_insn_i,
    // register file, read data same cycle
    input  wire word_t gpr_rd_data_0_i,
    input  wire word_t gpr_rd_data_1_i,
    output reg_addr_t  gpr_rd_addr_0_o,
    output reg_addr_t  gpr_rd_addr_1_o,
    // towards EX
    output logic       id_en_o,
    output alu_op_t    id_alu_op_o,
    output word_t      id_alu_in_0_o,
    output word_t      id_alu_in_1_o,
    output mem_op_t    id_mem_op_o,
    output word_t      id_mem_wr_data_o,
    output gpr_src_t   id_gpr_src_o,
    output reg_addr_t  id_dst_addr_o,
    output logic       id_gpr_we_o,
    output logic       id_illegal_o
);

    // ------------------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------------------
    word_t imm_i;
    word_t imm_shamt;
    word_t imm_s;

    imm_gen i_imm_gen (
        .insn_i      (if_insn_i),
        .imm_i_o     (imm_i),
        .imm_shamt_o (imm_shamt),
        .imm_s_o     (imm_s)
    );

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    alu_op_t   alu_op;
    word_t     alu_in_0;
    word_t     alu_in_1;
    mem_op_t   mem_op;
    word_t     mem_wr_data;
    gpr_src_t  gpr_src;
    reg_addr_t dst_addr;
    logic      gpr_we;
    logic      illegal;

    insn_decode i_insn_decode (
        .if_en_i         (if_en_i),
        .if_insn_i       (if_insn_i),
        .gpr_rd_data_0_i (gpr_rd_data_0_i),
        .gpr_rd_data_1_i (gpr_rd_data_1_i),
        .imm_i_i         (imm_i),
        .imm_shamt_i     (imm_shamt),
        .imm_s_i         (imm_s),
        .gpr_rd_addr_0_o (gpr_rd_addr_0_o),
        .gpr_rd_addr_1_o (gpr_rd_addr_1_o),
        .alu_op_o        (alu_op),
        .alu_in_0_o      (alu_in_0),
        .alu_in_1_o      (alu_in_1),
        .mem_op_o        (mem_op),
        .mem_wr_data_o   (mem_wr_data),
        .gpr_src_o       (gpr_src),
        .dst_addr_o      (dst_addr),
        .gpr_we_o        (gpr_we),
        .illegal_o       (illegal)
    );

    // ------------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------------
    id_ex_reg i_id_ex_reg (
        .clk              (clk),
        .reset_i          (reset_i),
        .en_i             (if_en_i),
        .alu_op_i         (alu_op),
        .alu_in_0_i       (alu_in_0),
        .alu_in_1_i       (alu_in_1),
        .mem_op_i         (mem_op),
        .mem_wr_data_i    (mem_wr_data),
        .gpr_src_i        (gpr_src),
        .dst_addr_i       (dst_addr),
        .gpr_we_i         (gpr_we),
        .illegal_i        (illegal),
        .id_en_o          (id_en_o),
        .id_alu_op_o      (id_alu_op_o),
        .id_alu_in_0_o    (id_alu_in_0_o),
        .id_alu_in_1_o    (id_alu_in_1_o),
        .id_mem_op_o      (id_mem_op_o),
        .id_mem_wr_data_o (id_mem_wr_data_o),
        .id_gpr_src_o     (id_gpr_src_o),
        .id_dst_addr_o    (id_dst_addr_o),
        .id_gpr_we_o      (id_gpr_we_o),
        .id_illegal_o     (id_illegal_o)
    );

endmodule

`default_nettype wire

//--- logic/id_ex_reg.sv
// ID/EX pipeline register.
// Captures the decoded controls and operands on every rising clock edge,
// one cycle after decode. Synchronous reset returns the control fields
// to idle; operand and address fields simply follow the decoder.

`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import id_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire logic      en_i,
    input  wire alu_op_t   alu_op_i,
    input  wire word_t     alu_in_0_i,
    input  wire word_t     alu_in_1_i,
    input  wire mem_op_t   mem_op_i,
    input  wire word_t     mem_wr_data_i,
    input  wire gpr_src_t  gpr_src_i,
    input  wire reg_addr_t dst_addr_i,
    input  wire logic      gpr_we_i,
    input  wire logic      illegal_i,
    output logic           id_en_o,
    output alu_op_t        id_alu_op_o,
    output word_t          id_alu_in_0_o,
    output word_t          id_alu_in_1_o,
    output mem_op_t        id_mem_op_o,
    output word_t          id_mem_wr_data_o,
    output gpr_src_t       id_gpr_src_o,
    output reg_addr_t      id_dst_addr_o,
    output logic           id_gpr_we_o,
    output logic           id_illegal_o
);

    // ------------------------------------------------------------------------
    // control fields
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            // idle, nothing valid in EX
            id_en_o      <= 1'b0;
            id_alu_op_o  <= ALU_OP_NOP;
            id_mem_op_o  <= MEM_OP_NOP;
            id_gpr_we_o  <= 1'b0;
            id_illegal_o <= 1'b0;
        end else begin
            id_en_o      <= en_i;
            id_alu_op_o  <= alu_op_i;
            id_mem_op_o  <= mem_op_i;
            id_gpr_we_o  <= gpr_we_i;
            id_illegal_o <= illegal_i;
        end
    end

    // operands, store data and addresses
    always_ff @(posedge clk) begin
        id_alu_in_0_o    <= alu_in_0_i;
        id_alu_in_1_o    <= alu_in_1_i;
        id_mem_wr_data_o <= mem_wr_data_i;
        id_gpr_src_o     <= gpr_src_i;
        id_dst_addr_o    <= dst_addr_i;
    end

endmodule

`default_nettype wire

//--- logic/insn_decode.sv
// Combinational instruction decoder for the ID stage.
// Splits the instruction into register addresses, picks the ALU operands
// from read data or an immediate, and sets the ALU, memory and write-back
// controls. Unknown encodings raise the illegal flag with all controls idle.
// With the enable low everything is idle and nothing is flagged.

`timescale 1ns/1ps
`default_nettype none

module insn_decode
    import id_pkg::*;
(
    input  wire logic  if_en_i,
    input  wire word_t if_insn_i,
    input  wire word_t gpr_rd_data_0_i,
    input  wire word_t gpr_rd_data_1_i,
    input  wire word_t imm_i_i,
    input  wire word_t imm_shamt_i,
    input  wire word_t imm_s_i,
    output reg_addr_t  gpr_rd_addr_0_o,
    output reg_addr_t  gpr_rd_addr_1_o,
    output alu_op_t    alu_op_o,
    output word_t      alu_in_0_o,
    output word_t      alu_in_1_o,
    output mem_op_t    mem_op_o,
    output word_t      mem_wr_data_o,
    output gpr_src_t   gpr_src_o,
    output reg_addr_t  dst_addr_o,
    output logic       gpr_we_o,
    output logic       illegal_o
);

    // ------------------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------------------
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = if_insn_i[6:0];
    assign funct3 = if_insn_i[14:12];
    assign funct7 = if_insn_i[31:25];

    // rs1 / rs2 straight to the register file, no enable
    assign gpr_rd_addr_0_o = if_insn_i[19:15];
    assign gpr_rd_addr_1_o = if_insn_i[24:20];
    assign dst_addr_o      = if_insn_i[11:7];

    // stores always write rs2
    assign mem_wr_data_o = gpr_rd_data_1_i;

    // ------------------------------------------------------------------------
    // control decode
    // ------------------------------------------------------------------------
    always_comb begin
        // idle defaults, operands from the register file
        alu_op_o   = ALU_OP_NOP;
        alu_in_0_o = gpr_rd_data_0_i;
        alu_in_1_o = gpr_rd_data_1_i;
        mem_op_o   = MEM_OP_NOP;
        gpr_src_o  = GPR_SRC_EX;
        gpr_we_o   = 1'b0;
        illegal_o  = 1'b0;

        if (if_en_i) begin
            case (opcode)
                OP_NOP: begin
                    // legal, nothing to do
                    alu_op_o = ALU_OP_NOP;
                end
                OP_LOAD: begin
                    // address = rs1 + imm_i
                    alu_op_o   = ALU_OP_ADD;
                    alu_in_1_o = imm_i_i;
                    gpr_we_o   = 1'b1;
                    gpr_src_o  = GPR_SRC_MEM;
                    case (funct3)
                        F3_LB:   mem_op_o = MEM_OP_LB;
                        F3_LH:   mem_op_o = MEM_OP_LH;
                        F3_LW:   mem_op_o = MEM_OP_LW;
                        F3_LBU:  mem_op_o = MEM_OP_LBU;
                        F3_LHU:  mem_op_o = MEM_OP_LHU;
                        default: illegal_o = 1'b1;
                    endcase
                end
                OP_STORE: begin
                    // address = rs1 + imm_s, no write-back
                    alu_op_o   = ALU_OP_ADD;
                    alu_in_1_o = imm_s_i;
                    case (funct3)
                        F3_SB:   mem_op_o = MEM_OP_SB;
                        F3_SH:   mem_op_o = MEM_OP_SH;
                        F3_SW:   mem_op_o = MEM_OP_SW;
                        default: illegal_o = 1'b1;
                    endcase
                end
                OP_ALU_IMM: begin
                    alu_in_1_o = imm_i_i;
                    gpr_we_o   = 1'b1;
                    case (funct3)
                        F3_ADD: alu_op_o = ALU_OP_ADD;
                        F3_XOR: alu_op_o = ALU_OP_XOR;
                        F3_OR:  alu_op_o = ALU_OP_OR;
                        F3_AND: alu_op_o = ALU_OP_AND;
                        F3_SLL: begin
                            // shifts take the 5-bit shamt instead
                            alu_op_o   = ALU_OP_SLL;
                            alu_in_1_o = imm_shamt_i;
                            illegal_o  = (funct7 != F7_BASE);
                        end
                        F3_SR: begin
                            alu_in_1_o = imm_shamt_i;
                            if (funct7 == F7_BASE) begin
                                alu_op_o = ALU_OP_SRL;
                            end else if (funct7 == F7_ALT) begin
                                alu_op_o = ALU_OP_SRA;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                        // slti / sltiu not supported
                        default: illegal_o = 1'b1;
                    endcase
                end
                OP_ALU_REG: begin
                    gpr_we_o = 1'b1;
                    case (funct3)
                        F3_ADD: begin
                            if (funct7 == F7_BASE) begin
                                alu_op_o = ALU_OP_ADD;
                            end else if (funct7 == F7_ALT) begin
                                alu_op_o = ALU_OP_SUB;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                        F3_SR: begin
                            if (funct7 == F7_BASE) begin
                                alu_op_o = ALU_OP_SRL;
                            end else if (funct7 == F7_ALT) begin
                                alu_op_o = ALU_OP_SRA;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                        F3_SLL: begin
                            alu_op_o  = ALU_OP_SLL;
                            illegal_o = (funct7 != F7_BASE);
                        end
                        F3_XOR: begin
                            alu_op_o  = ALU_OP_XOR;
                            illegal_o = (funct7 != F7_BASE);
                        end
                        F3_OR: begin
                            alu_op_o  = ALU_OP_OR;
                            illegal_o = (funct7 != F7_BASE);
                        end
                        F3_AND: begin
                            alu_op_o  = ALU_OP_AND;
                            illegal_o = (funct7 != F7_BASE);
                        end
                        // slt / sltu not supported
                        default: illegal_o = 1'b1;
                    endcase
                end
                default: illegal_o = 1'b1;
            endcase

            // flagged insn leaves the pipe with no side effects
            if (illegal_o) begin
                alu_op_o  = ALU_OP_NOP;
                mem_op_o  = MEM_OP_NOP;
                gpr_src_o = GPR_SRC_EX;
                gpr_we_o  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
// Immediate generator for the decode stage.
// Pulls the I, shift-amount and S immediates out of one instruction word.
// Purely combinational; the decoder picks whichever one it needs.

`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import id_pkg::*;
(
    input  wire word_t insn_i,
    output word_t      imm_i_o,
    output word_t      imm_shamt_o,
    output word_t      imm_s_o
);

    // ------------------------------------------------------------------------
    // immediate extraction
    // ------------------------------------------------------------------------

    // i format, 12 bits, sign from bit 31
    assign imm_i_o = {{20{insn_i[31]}}, insn_i[31:20]};

    // shift amount, 5 bits, zero extended
    assign imm_shamt_o = {27'b0, insn_i[24:20]};

    // s format, split across the rs2 field
    // upper part in 31..25, lower part in the rd slot
    assign imm_s_o = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};

endmodule

`default_nettype wire

//--- logic/id_pkg.sv
// Shared types and encodings for the instruction-decode stage.
// Holds the word and register-address types, the RV32I opcode and funct
// fields used by the decoder, and the ALU, memory and write-back codes
// carried in the ID/EX register. Import with a wildcard where needed.

`default_nettype none

package id_pkg;

    // ------------------------------------------------------------------------
    // basic widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, standard rv32i values
    localparam opcode_t OP_NOP     = 7'b0000000;
    localparam opcode_t OP_LOAD    = 7'b0000011;
    localparam opcode_t OP_STORE   = 7'b0100011;
    localparam opcode_t OP_ALU_IMM = 7'b0010011;
    localparam opcode_t OP_ALU_REG = 7'b0110011;

    // load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store widths
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // alu funct3, shared by reg and imm forms
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_SR  = 3'b101;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // funct7, alt form selects sub and sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // ------------------------------------------------------------------------
    // operation codes towards EX and MEM
    // ------------------------------------------------------------------------
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_OP_NOP = 4'd0;
    localparam alu_op_t ALU_OP_ADD = 4'd1;
    localparam alu_op_t ALU_OP_SUB = 4'd2;
    localparam alu_op_t ALU_OP_SLL = 4'd3;
    localparam alu_op_t ALU_OP_SRL = 4'd4;
    localparam alu_op_t ALU_OP_SRA = 4'd5;
    localparam alu_op_t ALU_OP_AND = 4'd6;
    localparam alu_op_t ALU_OP_OR  = 4'd7;
    localparam alu_op_t ALU_OP_XOR = 4'd8;

    typedef logic [3:0] mem_op_t;

    localparam mem_op_t MEM_OP_NOP = 4'd0;
    localparam mem_op_t MEM_OP_LB  = 4'd1;
    localparam mem_op_t MEM_OP_LH  = 4'd2;
    localparam mem_op_t MEM_OP_LW  = 4'd3;
    localparam mem_op_t MEM_OP_LBU = 4'd4;
    localparam mem_op_t MEM_OP_LHU = 4'd5;
    localparam mem_op_t MEM_OP_SB  = 4'd6;
    localparam mem_op_t MEM_OP_SH  = 4'd7;
    localparam mem_op_t MEM_OP_SW  = 4'd8;

    // write-back source for the gpr file
    typedef logic gpr_src_t;

    localparam gpr_src_t GPR_SRC_EX  = 1'b0;
    localparam gpr_src_t GPR_SRC_MEM = 1'b1;

endpackage

`default_nettype wire
